//--- common/rn_pkg.sv
// Rename stage types and widths
package rn_pkg;

   localparam int RN_IW     = 2;                 // Rename slots per cycle
   localparam int RN_CW     = 2;                 // Commit slots per cycle
   localparam int RN_PRF_AW = 6;                 // Physical register index
   localparam int RN_N_PRF  = 1 << RN_PRF_AW;
   localparam int RN_ARF_AW = 5;                 // Architectural register index
   localparam int RN_N_ARF  = 1 << RN_ARF_AW;

   // Upper half free out of reset
   // Lower half is held by the identity map
   localparam logic [RN_N_PRF-1:0] RN_FL_RESET =
      {{(RN_N_PRF-RN_N_ARF){1'b1}}, {RN_N_ARF{1'b0}}};

   // One rename slot from decode
   typedef struct packed
   {
      logic                 valid;
      logic [RN_ARF_AW-1:0] lrs1;             // Source 1
      logic [RN_ARF_AW-1:0] lrs2;             // Source 2
      logic [RN_ARF_AW-1:0] lrd;              // Destination
      logic                 lrd_we;           // Destination written
   } rn_req_t;

   // One renamed slot
   typedef struct packed
   {
      logic [RN_PRF_AW-1:0] prs1;
      logic [RN_PRF_AW-1:0] prs2;
      logic [RN_PRF_AW-1:0] prd;              // Newly taken register
      logic [RN_PRF_AW-1:0] pfree;            // Old mapping of lrd
   } rn_rsp_t;

   // One commit slot from the ROB
   typedef struct packed
   {
      logic                 fire;
      logic                 prd_we;
      logic [RN_ARF_AW-1:0] lrd;
      logic [RN_PRF_AW-1:0] prd;              // Becomes architectural
      logic [RN_PRF_AW-1:0] pfree;            // Released to both lists
   } rn_cmt_t;

endpackage

//--- hdl/priority_encoder.sv
`timescale 1ns/1ps
// Lowest set bit encoder
module priority_encoder
   import rn_pkg::*;
(
   input  logic [RN_N_PRF-1:0]  din,
   output logic [RN_PRF_AW-1:0] dout,
   output logic                 gs
);

   // Scan from the top so the lowest hit is written last
   always_comb
   begin
      dout = '0;                                // Zero when nothing set
      for (int i = RN_N_PRF - 1; i >= 0; i--)
      begin
         if (din[i])
         begin
            dout = RN_PRF_AW'(i);
         end
      end
   end

   assign gs = |din;                            // Any bit set

endmodule

//--- rename/rn_fl.sv
`timescale 1ns/1ps
// Physical register free lists
module rn_fl
   import rn_pkg::*;
(
   input  logic                            clk,
   input  logic                            arst_n,
   input  rn_req_t [RN_IW-1:0]             req,
   input  rn_cmt_t [RN_CW-1:0]             cmt,
   input  logic                            rollback,
   output logic [RN_IW-1:0][RN_PRF_AW-1:0] prd,
   output logic [RN_IW-1:0]                alloc,
   output logic                            stall
);

   logic [RN_N_PRF-1:0] fl_q;                   // Speculative list, 1 = free
   logic [RN_N_PRF-1:0] afl_q;                  // Architectural list
   logic [RN_N_PRF-1:0] fl_nxt;
   logic [RN_N_PRF-1:0] afl_nxt;
   logic [RN_N_PRF-1:0] cand [RN_IW];           // Encoder input per slot
   logic [RN_IW-1:0]    gs;                     // Slot found a free register
   logic [RN_IW-1:0]    wr;                     // Slot wants a destination
   logic [RN_N_PRF-1:0] alloc_mask;             // Bits taken this cycle
   logic [RN_N_PRF-1:0] free_mask;              // Bits released at commit

   // Each later slot sees the list minus the picks before it
   genvar g;
   generate
      for (g = 0; g < RN_IW; g++)
      begin : gen_pick
         if (g == 0)
         begin : gen_first
            assign cand[g] = fl_q;
         end
         else
         begin : gen_next
            assign cand[g] = cand[g-1] & ~(RN_N_PRF'(1) << prd[g-1]);
         end

         priority_encoder penc (
            .din  (cand[g]),
            .dout (prd[g]),
            .gs   (gs[g])
         );

         assign wr[g] = req[g].valid & req[g].lrd_we;
      end
   endgenerate

   // Whole group waits if any writer comes up empty
   assign stall = |(wr & ~gs);
   assign alloc = wr & {RN_IW{~stall & ~rollback}};

   always_comb
   begin
      alloc_mask = '0;
      free_mask  = '0;
      afl_nxt    = afl_q;
      for (int i = 0; i < RN_IW; i++)
      begin
         if (alloc[i])
         begin
            alloc_mask = alloc_mask | (RN_N_PRF'(1) << prd[i]);
         end
      end
      for (int i = 0; i < RN_CW; i++)
      begin
         if (cmt[i].fire && cmt[i].prd_we)
         begin
            free_mask = free_mask | (RN_N_PRF'(1) << cmt[i].pfree);
            afl_nxt   = afl_nxt & ~(RN_N_PRF'(1) << cmt[i].prd);   // Now architectural
            afl_nxt   = afl_nxt | (RN_N_PRF'(1) << cmt[i].pfree);  // Old value dies
         end
      end
      fl_nxt = (fl_q & ~alloc_mask) | free_mask;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         fl_q  <= RN_FL_RESET;
         afl_q <= RN_FL_RESET;
      end
      else
      begin
         fl_q  <= rollback ? afl_q : fl_nxt;    // Restore on flush
         afl_q <= afl_nxt;                      // Commits only
      end
   end

   // Decode picks and ROB frees must not overlap
   a_alloc_free: assert property (@(posedge clk) disable iff (!arst_n)
      (alloc_mask & free_mask) == '0)
      else $error("rn_fl: register allocated and freed in one cycle");

   // p0 stays bound to x0 in both lists
   a_p0_busy: assert property (@(posedge clk) disable iff (!arst_n)
      !fl_q[0] && !afl_q[0])
      else $error("rn_fl: physical register 0 marked free");

   a_rb_cmt: assert property (@(posedge clk) disable iff (!arst_n)
      rollback |-> !(cmt[0].fire || cmt[1].fire))
      else $error("rn_fl: rollback together with commit");

endmodule

//--- rename/rn_rat.sv
`timescale 1ns/1ps
// Register alias tables
module rn_rat
   import rn_pkg::*;
(
   input  logic                            clk,
   input  logic                            arst_n,
   input  rn_req_t [RN_IW-1:0]             req,
   input  logic [RN_IW-1:0][RN_PRF_AW-1:0] prd,
   input  logic [RN_IW-1:0]                alloc,
   input  rn_cmt_t [RN_CW-1:0]             cmt,
   input  logic                            rollback,
   output rn_rsp_t [RN_IW-1:0]             rsp
);

   logic [RN_PRF_AW-1:0] smap [RN_N_ARF];       // Speculative table
   logic [RN_PRF_AW-1:0] amap [RN_N_ARF];       // Architectural table

   // Lookup with bypass from older slots in the group
   always_comb
   begin
      for (int i = 0; i < RN_IW; i++)
      begin
         rsp[i].prs1  = smap[req[i].lrs1];
         rsp[i].prs2  = smap[req[i].lrs2];
         rsp[i].pfree = smap[req[i].lrd];       // Old mapping
         rsp[i].prd   = prd[i];                 // From the free list
         for (int j = 0; j < i; j++)
         begin
            // Youngest older writer wins
            if (req[j].valid && req[j].lrd_we)
            begin
               if (req[i].lrs1 == req[j].lrd)
               begin
                  rsp[i].prs1 = prd[j];
               end
               if (req[i].lrs2 == req[j].lrd)
               begin
                  rsp[i].prs2 = prd[j];
               end
               if (req[i].lrd == req[j].lrd)
               begin
                  rsp[i].pfree = prd[j];        // Freed when this slot commits
               end
            end
         end
      end
   end

   // Speculative table
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int n = 0; n < RN_N_ARF; n++)
         begin
            smap[n] <= RN_PRF_AW'(n);           // Identity map
         end
      end
      else if (rollback)
      begin
         for (int n = 0; n < RN_N_ARF; n++)
         begin
            smap[n] <= amap[n];                 // Whole table in one cycle
         end
      end
      else
      begin
         for (int i = 0; i < RN_IW; i++)
         begin
            if (alloc[i])
            begin
               smap[req[i].lrd] <= prd[i];      // Later slot overrides
            end
         end
      end
   end

   // Architectural table
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int n = 0; n < RN_N_ARF; n++)
         begin
            amap[n] <= RN_PRF_AW'(n);
         end
      end
      else
      begin
         for (int i = 0; i < RN_CW; i++)
         begin
            if (cmt[i].fire && cmt[i].prd_we)
            begin
               amap[cmt[i].lrd] <= cmt[i].prd;  // Slot order
            end
         end
      end
   end

   // x0 never renamed
   genvar g;
   generate
      for (g = 0; g < RN_IW; g++)
      begin : gen_chk
         a_no_x0: assert property (@(posedge clk) disable iff (!arst_n)
            (req[g].valid && req[g].lrd_we) |-> (req[g].lrd != '0))
            else $error("rn_rat: slot %0d writes x0", g);
      end
   endgenerate

   // Free list must hold off allocation during a flush
   a_rb_alloc: assert property (@(posedge clk) disable iff (!arst_n)
      rollback |-> (alloc == '0))
      else $error("rn_rat: allocation during rollback");

endmodule

//--- rename/rn_top.sv
`timescale 1ns/1ps
// Register rename stage
module rn_top
   import rn_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  rn_req_t [RN_IW-1:0] req,
   input  rn_cmt_t [RN_CW-1:0] cmt,
   input  logic                rollback,
   output rn_rsp_t [RN_IW-1:0] rsp,
   output logic                stall
);

   // Free list to alias table
   logic [RN_IW-1:0][RN_PRF_AW-1:0] fl_prd;     // Picked register per slot
   logic [RN_IW-1:0]                fl_alloc;   // Slot consumed this cycle

   // Allocation and stall
   rn_fl fl0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (req),
      .cmt      (cmt),
      .rollback (rollback),
      .prd      (fl_prd),
      .alloc    (fl_alloc),
      .stall    (stall)
   );

   // Lookup and table update
   // prd rides through the table block into rsp
   rn_rat rat0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (req),
      .prd      (fl_prd),
      .alloc    (fl_alloc),
      .cmt      (cmt),
      .rollback (rollback),
      .rsp      (rsp)
   );

endmodule

//--- testbench/tb_rename.sv
`timescale 1ns/1ps
// Rename stage testbench
module tb_rename
   import rn_pkg::*;
();

   localparam int N_ROWS     = 27;              // Directed rows
   localparam int N_RAND     = 200;             // Random rows
   localparam int HOLD_LIMIT = 40;              // Max cycles a group may stall

   // One directed cycle
   typedef struct packed
   {
      rn_req_t    r0;
      rn_req_t    r1;
      logic [1:0] ncmt;                         // Queue entries to commit
      logic       rb;                           // Rollback strobe
      logic       exp_stall;
   } row_t;

   logic                clk;
   logic                arst_n;
   logic                rollback;
   logic                stall;
   rn_req_t [RN_IW-1:0] req;
   rn_cmt_t [RN_CW-1:0] cmt;
   rn_rsp_t [RN_IW-1:0] rsp;

   // Reference model
   logic [RN_PRF_AW-1:0] m_smap [RN_N_ARF];     // Speculative map
   logic [RN_PRF_AW-1:0] m_amap [RN_N_ARF];     // Architectural map
   logic [RN_N_PRF-1:0]  m_fl;                  // Speculative free vector
   logic [RN_N_PRF-1:0]  m_afl;                 // Architectural free vector
   rn_cmt_t              cq [$];                // Renamed, not yet committed
   logic                 m_stall;               // Predicted stall

   row_t        rows [N_ROWS];
   logic [31:0] lfsr;
   int          n_mis;
   int          n_other;

   rn_top dut0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (req),
      .cmt      (cmt),
      .rollback (rollback),
      .rsp      (rsp),
      .stall    (stall)
   );

   always #10 clk = ~clk;                       // 20 ns period

   function automatic rn_req_t mk_req(input logic v, input logic [4:0] s1,
                                      input logic [4:0] s2, input logic [4:0] d,
                                      input logic we);
      return {v, s1, s2, d, we};
   endfunction

   // Index of lowest free register or -1
   function automatic int lowest_free(input logic [RN_N_PRF-1:0] v);
      for (int i = 0; i < RN_N_PRF; i++)
      begin
         if (v[i])
         begin
            return i;
         end
      end
      return -1;
   endfunction

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic random_req(output rn_req_t r);
      logic [31:0] b;
      take_bits(2, b);
      r.valid = |b[1:0];                        // Valid 3 of 4
      take_bits(5, b);
      r.lrs1 = b[4:0];
      take_bits(5, b);
      r.lrs2 = b[4:0];
      take_bits(5, b);
      r.lrd = b[4:0];
      take_bits(2, b);
      r.lrd_we = (|b[1:0]) && (r.lrd != 5'd0);  // x0 never written
   endtask

   task automatic random_row(output rn_req_t r0, output rn_req_t r1,
                             output int nc, output logic rb);
      logic [31:0] b;
      random_req(r0);
      random_req(r1);
      take_bits(3, b);
      nc = (b == 7) ? 2 : ((b >= 5) ? 1 : 0);   // Fewer commits than renames
      take_bits(6, b);
      rb = (b == 63);                           // Rare flush
      if (rb)
      begin
         nc = 0;
      end
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
         n_mis++;
      end
   endtask

   task automatic check_slot(input int s, input rn_req_t r, input rn_rsp_t e);
      if (r.valid)
      begin
         check_field($sformatf("rsp[%0d].prs1", s), rsp[s].prs1, e.prs1);
         check_field($sformatf("rsp[%0d].prs2", s), rsp[s].prs2, e.prs2);
         if (r.lrd_we)
         begin
            check_field($sformatf("rsp[%0d].prd", s), rsp[s].prd, e.prd);
            check_field($sformatf("rsp[%0d].pfree", s), rsp[s].pfree, e.pfree);
         end
      end
   endtask

   // Drive one cycle, check before the edge, then advance the model
   task automatic apply_row(input rn_req_t r0, input rn_req_t r1, input int nc,
                            input logic rb);
      int      n;
      int      p0;
      int      p1;
      logic    w0;
      logic    w1;
      rn_rsp_t e0;
      rn_rsp_t e1;
      rn_cmt_t c;
      @(posedge clk);
      #2;
      n      = (nc > cq.size()) ? cq.size() : nc;
      req[0] = r0;
      req[1] = r1;
      cmt    = '0;
      for (int k = 0; k < n; k++)
      begin
         cmt[k] = cq[k];                        // Oldest first
      end
      rollback = rb;
      p0 = lowest_free(m_fl);
      p1 = (p0 < 0) ? -1 : lowest_free(m_fl & ~(RN_N_PRF'(1) << p0));
      w0 = r0.valid & r0.lrd_we;
      w1 = r1.valid & r1.lrd_we;
      m_stall  = (w0 && p0 < 0) || (w1 && p1 < 0);
      e0.prs1  = m_smap[r0.lrs1];
      e0.prs2  = m_smap[r0.lrs2];
      e0.pfree = m_smap[r0.lrd];
      e0.prd   = RN_PRF_AW'(p0);
      e1.prs1  = (w0 && r1.lrs1 == r0.lrd) ? e0.prd : m_smap[r1.lrs1];
      e1.prs2  = (w0 && r1.lrs2 == r0.lrd) ? e0.prd : m_smap[r1.lrs2];
      e1.pfree = (w0 && r1.lrd == r0.lrd) ? e0.prd : m_smap[r1.lrd];
      e1.prd   = RN_PRF_AW'(p1);
      #8;                                       // Mid cycle, inputs settled
      check_field("stall", stall, m_stall);
      if (!m_stall)
      begin
         check_slot(0, r0, e0);
         check_slot(1, r1, e1);
      end
      if (rb)
      begin
         m_fl = m_afl;                          // Flush to committed state
         for (int a = 0; a < RN_N_ARF; a++)
         begin
            m_smap[a] = m_amap[a];
         end
         cq.delete();
      end
      else
      begin
         for (int k = 0; k < n; k++)
         begin
            c = cq.pop_front();
            m_afl[c.prd]   = 1'b0;
            m_afl[c.pfree] = 1'b1;              // Old value dead
            m_fl[c.pfree]  = 1'b1;
            m_amap[c.lrd]  = c.prd;
         end
         if (!m_stall && w0)
         begin
            m_fl[p0]       = 1'b0;
            m_smap[r0.lrd] = e0.prd;
            c = {1'b1, 1'b1, r0.lrd, e0.prd, e0.pfree};
            cq.push_back(c);
         end
         if (!m_stall && w1)
         begin
            m_fl[p1]       = 1'b0;
            m_smap[r1.lrd] = e1.prd;            // Younger slot wins
            c = {1'b1, 1'b1, r1.lrd, e1.prd, e1.pfree};
            cq.push_back(c);
         end
      end
   endtask

   task automatic finish_run();
      $display("Errors: %0d mismatches, %0d other failures", n_mis, n_other);
      if (n_mis == 0 && n_other == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   // Hold the group and commit until stall drops
   task automatic wait_stall_clear(input rn_req_t r0, input rn_req_t r1,
                                   output logic hung);
      int t;
      t    = 0;
      hung = 1'b0;
      while (stall && t < HOLD_LIMIT)
      begin
         apply_row(r0, r1, 1, 1'b0);
         t++;
      end
      if (stall)
      begin
         $display("Timeout: stall still high after %0d held cycles", HOLD_LIMIT);
         n_other++;
         hung = 1'b1;
      end
   endtask

   task automatic model_reset();
      for (int a = 0; a < RN_N_ARF; a++)
      begin
         m_smap[a] = RN_PRF_AW'(a);             // Identity map
         m_amap[a] = RN_PRF_AW'(a);
      end
      for (int p = 0; p < RN_N_PRF; p++)
      begin
         m_fl[p]  = (p >= RN_N_ARF);            // Upper half free
         m_afl[p] = (p >= RN_N_ARF);
      end
      cq.delete();
   endtask

   task automatic set_row(input int i, input rn_req_t r0, input rn_req_t r1,
                          input int nc, input logic rb, input logic es);
      rows[i] = {r0, r1, 2'(nc), rb, es};
   endtask

   task automatic build_table();
      rn_req_t none;
      rn_req_t w5;
      none = '0;
      w5   = mk_req(1'b1, 5'd1, 5'd4, 5'd5, 1'b1);
      set_row(0, mk_req(1, 2, 3, 1, 1), mk_req(1, 1, 5, 4, 1), 0, 0, 0);  // Bypass on lrs1
      set_row(1, mk_req(1, 1, 4, 6, 1), mk_req(1, 6, 0, 6, 1), 0, 0, 0);  // Shared lrd
      set_row(2, none, none, 2, 0, 0);          // Free p1 and p4
      set_row(3, mk_req(1, 6, 4, 7, 1), mk_req(1, 7, 1, 8, 1), 0, 0, 0);  // Reuse p1, p4
      // Drain the remaining 28 free registers
      for (int k = 0; k < 14; k++)
      begin
         set_row(4 + k, mk_req(1, 5'(k + 1), 5'(k + 2), 5'(9 + k % 11), 1),
                 mk_req(1, 5'(9 + k % 11), 5'd3, 5'(20 + k % 11), 1), 0, 0, 0);
      end
      set_row(18, w5, none, 0, 0, 1);
      set_row(19, mk_req(1, 6, 7, 0, 0), mk_req(1, 8, 1, 0, 0), 0, 0, 0); // No writes
      set_row(20, w5, none, 0, 0, 1);
      set_row(21, w5, none, 1, 0, 1);           // Commit lands next edge
      set_row(22, w5, none, 0, 0, 0);
      set_row(23, none, none, 2, 0, 0);
      set_row(24, mk_req(1, 6, 7, 9, 1), none, 0, 1, 0);
      set_row(25, mk_req(1, 6, 7, 10, 1), mk_req(1, 10, 5, 11, 1), 0, 0, 0);
      set_row(26, none, none, 0, 0, 0);
   endtask

   initial
   begin
      rn_req_t r0;
      rn_req_t r1;
      int      nc;
      logic    rb;
      logic    hung;
      lfsr     = 32'heac69d09;
      n_mis    = 0;
      n_other  = 0;
      hung     = 1'b0;
      clk      = 1'b0;
      arst_n   = 1'b0;
      rollback = 1'b0;
      req      = '0;
      cmt      = '0;
      model_reset();
      build_table();
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;
      for (int i = 0; i < N_ROWS; i++)
      begin
         apply_row(rows[i].r0, rows[i].r1, rows[i].ncmt, rows[i].rb);
         check_field($sformatf("row %0d stall", i), stall, rows[i].exp_stall);
      end
      for (int i = 0; i < N_RAND && !hung; i++)
      begin
         random_row(r0, r1, nc, rb);
         apply_row(r0, r1, nc, rb);
         if (!rb)
         begin
            wait_stall_clear(r0, r1, hung);     // Stop early if stuck
         end
      end
      finish_run();
   end

endmodule

//--- build.f
common/rn_pkg.sv
hdl/priority_encoder.sv
rename/rn_fl.sv
rename/rn_rat.sv
rename/rn_top.sv
testbench/tb_rename.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rename \
   -f build.f -o sim_rename > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_rename > sim.log 2>&1 \
   || { echo "Simulation aborted, see sim.log"; exit 1; }

grep -q ">>> FAIL" sim.log \
   && { echo "Test failed, see sim.log"; exit 1; } \
   || { echo "Test passed"; exit 0; }
